// File: Makefile
SIM   = verilator
FLAGS = --binary --timing -Wno-fatal
TOP   = lumi_txphy_tb
FLIST = flist.f
LOG   = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/lumi_txphy_tb.sv
`timescale 1ns/100ps

module lumi_txphy_tb
   import lumi_tx_pkg::*;
   ();

   localparam int ACC_TIMEOUT   = 300;   // Cycles allowed for an accept
   localparam int HOLD_CYCLES   = 16;    // Window that must stay unaccepted
   localparam int DRAIN_TIMEOUT = 600;

   typedef struct {
      int          mode;     // 0 req, 1 resp, 2 resp paired with next row as req
      logic [4:0]  opc;
      logic [2:0]  size;
      logic [7:0]  len;
      int          iow;      // csr_iowidth
      int          en;       // csr_en
      int          crdt;     // rmt_crdt_req
      int          acc;      // 1 = must be accepted
      int          bp;       // Random phy_txrdy
      logic [31:0] dst;
      logic [31:0] src;
      logic [63:0] data;
   } row_t;

   logic              clk = 1'b0;
   logic              nreset;
   logic              csr_en;
   logic [2:0]        csr_iowidth;
   logic [CRDT_W-1:0] rmt_crdt_req;
   logic [CRDT_W-1:0] rmt_crdt_resp;
   logic              umi_req_in_valid;
   logic [CW-1:0]     umi_req_in_cmd;
   logic [AW-1:0]     umi_req_in_dstaddr;
   logic [AW-1:0]     umi_req_in_srcaddr;
   logic [DW-1:0]     umi_req_in_data;
   logic              umi_req_in_ready;
   logic              umi_resp_in_valid;
   logic [CW-1:0]     umi_resp_in_cmd;
   logic [AW-1:0]     umi_resp_in_dstaddr;
   logic [AW-1:0]     umi_resp_in_srcaddr;
   logic [DW-1:0]     umi_resp_in_data;
   logic              umi_resp_in_ready;
   logic [IOW-1:0]    phy_txdata;
   logic              phy_txvld;
   logic              phy_txrdy = 1'b1;

   integer     seed;
   int         errors;
   int         rem;           // Bytes left of packet on the wire
   int         beats;         // Consumed beats seen
   int         exp_beats;
   int         packets;
   bit         bp_on;
   bit         acc_last;      // Input handshake seen at the previous edge
   row_t       tbl[$];
   row_t       r;
   row_t       p;
   logic [7:0] exp_byte_q[$]; // Reference byte stream
   int         exp_len_q[$];

   lumi_txphy UUT (.*);

   always #2 clk = ~clk;      // 4 ns period

   always @(negedge clk)
      phy_txrdy = bp_on ? 1'($random(seed)) : 1'b1;   // Back-pressure source

   task automatic flag_error(input string msg);
      errors++;
      $display("%s", msg);
   endtask

   task automatic add_row(input int mode, input int opc, input int size, input int len,
                          input int iow, input int en, input int crdt, input int acc,
                          input int bp);
      row_t x;
      x = '{mode, 5'(opc), 3'(size), 8'(len), iow, en, crdt, acc, bp, 0, 0, 0};
      x.dst  = $random(seed);
      x.src  = $random(seed);
      x.data = {$random(seed), $random(seed)};
      tbl.push_back(x);
   endtask

   //########################################
   // Reference model
   //########################################
   function automatic int pkt_len(input row_t x);
      int d;
      d = (int'(x.len) + 1) << x.size;
      if (d > 8)
         d = 8;                                  // Data field cap
      if (x.opc == OPC_INVALID || x.opc == OPC_LINK)
         return 4;                               // Cmd only
      if (x.opc == OPC_READ || x.opc == OPC_RDMA || x.opc == OPC_ERROR ||
          x.opc == OPC_RESP_WRITE)
         return 12;
      return 12 + d;
   endfunction

   function automatic logic [159:0] pkt_word(input row_t x);
      logic [31:0] cmd;
      cmd = {16'h0000, x.len, x.size, x.opc};
      return {x.data, x.src, x.dst, cmd};        // Cmd in low bytes leaves first
   endfunction

   task automatic expect_pkt(input row_t x);
      logic [159:0] w;
      int           n;
      w = pkt_word(x);
      n = pkt_len(x);
      for (int i = 0; i < n; i++)
         exp_byte_q.push_back(w[8*i +: 8]);
      exp_len_q.push_back(n);
      exp_beats += (n + x.iow - 1) / x.iow;      // ceil(N / iowidth)
      packets++;
   endtask

   //########################################
   // Drivers
   //########################################
   task automatic drive_chan(input row_t x, input bit resp);
      logic [159:0] w;
      w = pkt_word(x);
      if (resp)
      begin
         umi_resp_in_valid = 1'b1;
         {umi_resp_in_data, umi_resp_in_srcaddr, umi_resp_in_dstaddr, umi_resp_in_cmd} = w;
      end
      else
      begin
         umi_req_in_valid = 1'b1;
         {umi_req_in_data, umi_req_in_srcaddr, umi_req_in_dstaddr, umi_req_in_cmd} = w;
      end
   endtask

   // Ready sampled at the rising edge before any register update
   task automatic await_accept(input row_t x, input bit resp);
      bit got;
      got = 1'b0;
      for (int c = 0; c < (x.acc ? ACC_TIMEOUT : HOLD_CYCLES) && !got; c++)
      begin
         @(posedge clk);
         got = resp ? umi_resp_in_ready : umi_req_in_ready;
      end
      if (got && x.acc)
         expect_pkt(x);
      else if (got)
         flag_error("Packet accepted while it should have been held back");
      else if (x.acc)
         flag_error(resp ? "Timeout waiting for response ready" :
                           "Timeout waiting for request ready");
   endtask

   task automatic drain();
      int c;
      c = 0;
      while ((exp_len_q.size() != 0 || rem != 0) && c < DRAIN_TIMEOUT)
      begin
         @(negedge clk);
         c++;
      end
      if (exp_len_q.size() != 0 || rem != 0)
         flag_error("Timeout waiting for the PHY output to drain");
   endtask

   //########################################
   // Monitor
   //########################################
   always @(posedge clk)
   begin : monitor
      int         step;
      logic [7:0] want;
      step = int'(csr_iowidth);
      // New packet must start right after its accept edge
      if (nreset && acc_last && (phy_txvld !== 1'b1 || rem != 0))
         flag_error("No first beat on the PHY in the cycle after an accept");
      acc_last = (umi_req_in_valid && umi_req_in_ready) ||
                 (umi_resp_in_valid && umi_resp_in_ready);
      if (nreset && phy_txvld)
      begin
         if (rem == 0 && exp_len_q.size() != 0)
            rem = exp_len_q.pop_front();          // First beat of next packet
         if (rem == 0)
            flag_error("phy_txvld high with no packet accepted");
         else
         begin
            if ((umi_req_in_ready || umi_resp_in_ready) && !(phy_txrdy && rem <= step))
               flag_error("Input ready high before the last beat was consumed");
            if (phy_txrdy)
            begin
               for (int k = 0; k < ((rem < step) ? rem : step); k++)
               begin
                  want = exp_byte_q.pop_front();
                  if (phy_txdata[8*k +: 8] !== want)
                     flag_error($sformatf("FAIL phy_txdata[%0d +: 8] got %h expected %h",
                                          8*k, phy_txdata[8*k +: 8], want));
               end
               rem   = (rem < step) ? 0 : rem - step;
               beats++;
            end
         end
      end
   end

   //########################################
   // Stimulus
   //########################################
   initial
   begin
      seed = 19;
      {errors, rem, beats, exp_beats, packets, bp_on, acc_last} = '0;
      nreset = 1'b0;
      csr_en = 1'b0;
      csr_iowidth = 3'd4;
      rmt_crdt_req = '1;
      rmt_crdt_resp = '1;
      umi_req_in_valid = 1'b0;
      {umi_req_in_cmd, umi_req_in_dstaddr, umi_req_in_srcaddr, umi_req_in_data} = '0;
      umi_resp_in_valid = 1'b0;
      {umi_resp_in_cmd, umi_resp_in_dstaddr, umi_resp_in_srcaddr, umi_resp_in_data} = '0;

      // Credit 30, then 40 after one 20-byte write
      add_row(0, OPC_WRITE, 0, 7, 4, 1, 30, 1, 0);
      add_row(0, OPC_WRITE, 0, 7, 4, 1, 30, 0, 0);
      add_row(0, OPC_WRITE, 0, 7, 4, 1, 40, 1, 0);
      add_row(0, OPC_WRITE_POSTED, 1, 1, 4, 0, 16'hffff, 0, 0);   // Disabled
      add_row(0, OPC_WRITE_POSTED, 1, 1, 4, 1, 16'hffff, 1, 0);
      for (int w = 1; w <= 4; w *= 2)
      begin
         add_row(0, OPC_READ, 3, 0, w, 1, 16'hffff, 1, 0);        // 12
         add_row(0, OPC_LINK, 0, 0, w, 1, 16'hffff, 1, 0);        // 4
         add_row(0, OPC_WRITE, 0, 3, w, 1, 16'hffff, 1, 0);       // 16
         add_row(0, OPC_WRITE, 0, 15, w, 1, 16'hffff, 1, 0);      // 20 after the data cap
         add_row(1, OPC_RESP_READ, 2, 1, w, 1, 16'hffff, 1, 0);   // 20
      end
      // Both channels at once
      add_row(2, OPC_RESP_WRITE, 0, 0, 4, 1, 16'hffff, 1, 0);
      add_row(0, OPC_WRITE, 3, 0, 4, 1, 16'hffff, 1, 0);
      add_row(2, OPC_RESP_READ, 0, 2, 2, 1, 16'hffff, 1, 0);
      add_row(0, OPC_ATOMIC, 1, 0, 2, 1, 16'hffff, 1, 0);
      for (int w = 1; w <= 4; w *= 2)
      begin
         add_row(0, OPC_ATOMIC, 2, 0, w, 1, 16'hffff, 1, 1);
         add_row(1, OPC_ERROR, 0, 0, w, 1, 16'hffff, 1, 1);
         add_row(0, 20, 0, 5, w, 1, 16'hffff, 1, 1);              // Unlisted opcode
         add_row(1, OPC_INVALID, 0, 0, w, 1, 16'hffff, 1, 1);
         add_row(2, OPC_RESP_READ, 3, 0, w, 1, 16'hffff, 1, 1);
         add_row(0, OPC_RDMA, 0, 0, w, 1, 16'hffff, 1, 1);
      end

      repeat (8) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;
      @(negedge clk);
      if (phy_txvld !== 1'b0)
         flag_error($sformatf("FAIL phy_txvld got %h expected 0", phy_txvld));
      if (umi_req_in_ready !== 1'b0 || umi_resp_in_ready !== 1'b0)
         flag_error($sformatf("FAIL umi_req_in_ready/umi_resp_in_ready got %h/%h expected 0/0",
                              umi_req_in_ready, umi_resp_in_ready));

      for (int i = 0; i < tbl.size(); i++)
      begin
         r = tbl[i];
         @(negedge clk);
         umi_req_in_valid  = 1'b0;
         umi_resp_in_valid = 1'b0;
         if (r.acc == 0 || r.en != int'(csr_en) || r.iow != int'(csr_iowidth) ||
             r.crdt != int'(rmt_crdt_req) || r.bp != int'(bp_on))
         begin
            drain();                                  // Controls change only when idle
            csr_en       = 1'(r.en);
            csr_iowidth  = 3'(r.iow);
            rmt_crdt_req = 16'(r.crdt);
            bp_on        = 1'(r.bp);
         end
         if (r.mode == 2)
         begin
            p = tbl[i+1];
            i++;
            drive_chan(r, 1'b1);
            drive_chan(p, 1'b0);
            await_accept(r, 1'b1);
            if (umi_req_in_ready)
               flag_error("Request accepted in the same cycle as a pending response");
            @(negedge clk);
            umi_resp_in_valid = 1'b0;
            await_accept(p, 1'b0);
         end
         else
         begin
            drive_chan(r, r.mode == 1);
            await_accept(r, r.mode == 1);
         end
      end

      @(negedge clk);
      umi_req_in_valid  = 1'b0;
      umi_resp_in_valid = 1'b0;
      drain();
      if (beats != exp_beats)
         flag_error($sformatf("FAIL beat count got %h expected %h", beats, exp_beats));
      $display("Packets: %0d  Beats: %0d  Errors: %0d", packets, beats, errors);
      if (errors == 0)
         $display("Testbench passed");
      else
         $display("Testbench failed");
      $finish;
   end

endmodule

// File: flist.f
verilog/lumi_tx_pkg.sv
verilog/lumi_tx_sizer.sv
verilog/lumi_tx_credit.sv
verilog/lumi_tx_arbiter.sv
verilog/lumi_tx_serializer.sv
verilog/lumi_txphy.sv
dv/lumi_txphy_tb.sv

// File: verilog/lumi_tx_arbiter.sv
`timescale 1ns/100ps

module lumi_tx_arbiter
   import lumi_tx_pkg::*;
   (
      input  logic             csr_en,           // Global accept enable
      input  logic             load_ready,       // Serializer can take a packet
      input  logic             req_crdt_ok,
      input  logic             resp_crdt_ok,
      input  logic [LEN_W-1:0] req_bytes,
      input  logic [LEN_W-1:0] resp_bytes,
      // Request channel
      input  logic             umi_req_in_valid,
      input  logic [CW-1:0]    umi_req_in_cmd,
      input  logic [AW-1:0]    umi_req_in_dstaddr,
      input  logic [AW-1:0]    umi_req_in_srcaddr,
      input  logic [DW-1:0]    umi_req_in_data,
      output logic             umi_req_in_ready,
      // Response channel
      input  logic             umi_resp_in_valid,
      input  logic [CW-1:0]    umi_resp_in_cmd,
      input  logic [AW-1:0]    umi_resp_in_dstaddr,
      input  logic [AW-1:0]    umi_resp_in_srcaddr,
      input  logic [DW-1:0]    umi_resp_in_data,
      output logic             umi_resp_in_ready,
      // To serializer and credit block
      output logic             load,
      output logic             load_resp,
      output logic [PKT_W-1:0] load_pkt,
      output logic [LEN_W-1:0] load_bytes
   );

   logic slot_free;   // Enabled and serializer free
   logic req_go;
   logic resp_go;

   //########################################
   // Qualify and grant
   //########################################
   assign slot_free = csr_en & load_ready;
   assign resp_go   = umi_resp_in_valid & resp_crdt_ok & slot_free;
   assign req_go    = umi_req_in_valid & req_crdt_ok & slot_free & ~resp_go;  // Resp wins

   assign umi_resp_in_ready = resp_go;
   assign umi_req_in_ready  = req_go;

   assign load      = resp_go | req_go;
   assign load_resp = resp_go;

   // Packet layout, cmd in low bytes so it leaves first
   always_comb
   begin
      if (resp_go)
      begin
         load_pkt   = {umi_resp_in_data, umi_resp_in_srcaddr,
                       umi_resp_in_dstaddr, umi_resp_in_cmd};
         load_bytes = resp_bytes;
      end
      else
      begin
         load_pkt   = {umi_req_in_data, umi_req_in_srcaddr,
                       umi_req_in_dstaddr, umi_req_in_cmd};
         load_bytes = req_bytes;
      end
   end

endmodule

// File: verilog/lumi_tx_credit.sv
`timescale 1ns/100ps

module lumi_tx_credit
   import lumi_tx_pkg::*;
   (
      input  logic              clk,
      input  logic              nreset,
      input  logic              load,           // Packet accepted this cycle
      input  logic              load_resp,      // 1 = accepted packet is a response
      input  logic [LEN_W-1:0]  load_bytes,     // Length of accepted packet
      input  logic [CRDT_W-1:0] rmt_crdt_req,   // Remote running limits
      input  logic [CRDT_W-1:0] rmt_crdt_resp,
      input  logic [LEN_W-1:0]  req_bytes,      // Pending lengths per channel
      input  logic [LEN_W-1:0]  resp_bytes,
      output logic              req_crdt_ok,
      output logic              resp_crdt_ok
   );

   logic [CRDT_W-1:0] sent_req;     // Bytes committed on request channel
   logic [CRDT_W-1:0] sent_resp;    // Bytes committed on response channel
   logic [CRDT_W-1:0] avail_req;
   logic [CRDT_W-1:0] avail_resp;

   //########################################
   // Sent-byte counters, wrap at 2**16
   //########################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
      begin
         sent_req  <= '0;
         sent_resp <= '0;
      end
      else if (load)
      begin
         if (load_resp)
            sent_resp <= sent_resp + CRDT_W'(load_bytes);
         else
            sent_req  <= sent_req + CRDT_W'(load_bytes);
      end
   end

   // Headroom is modulo difference, so limits may wrap too
   assign avail_req    = rmt_crdt_req - sent_req;
   assign avail_resp   = rmt_crdt_resp - sent_resp;
   assign req_crdt_ok  = avail_req >= CRDT_W'(req_bytes);
   assign resp_crdt_ok = avail_resp >= CRDT_W'(resp_bytes);

endmodule

// File: verilog/lumi_tx_pkg.sv
package lumi_tx_pkg;

   //########################################
   // Field and bus widths
   //########################################
   localparam int CW         = 32;                  // Command word
   localparam int AW         = 32;                  // Each address
   localparam int DW         = 64;                  // Data payload
   localparam int PKT_W      = DW + AW + AW + CW;   // Full packet, 160 bits
   localparam int PKT_BYTES  = PKT_W / 8;           // 20 bytes
   localparam int IOW        = 32;                  // PHY bus
   localparam int IO_BYTES   = IOW / 8;             // Widest beat in bytes
   localparam int HDR_BYTES  = (CW + AW + AW) / 8;  // Cmd plus both addresses
   localparam int CMD_BYTES  = CW / 8;              // Cmd alone
   localparam int DATA_BYTES = DW / 8;              // Data cap
   localparam int LEN_W      = 5;                   // Holds 0..PKT_BYTES
   localparam int CRDT_W     = 16;                  // Credit counters, wrapping

   //########################################
   // Command field positions
   //########################################
   localparam int OPC_LSB  = 0;
   localparam int OPC_W    = 5;
   localparam int SIZE_LSB = 5;   // Element size is 2**size bytes
   localparam int SIZE_W   = 3;
   localparam int LEN_LSB  = 8;   // Element count is len+1
   localparam int LEN_W8   = 8;

   //########################################
   // Opcodes
   //########################################
   localparam logic [OPC_W-1:0] OPC_INVALID      = 5'd0;
   localparam logic [OPC_W-1:0] OPC_READ         = 5'd2;
   localparam logic [OPC_W-1:0] OPC_WRITE_POSTED = 5'd3;
   localparam logic [OPC_W-1:0] OPC_WRITE        = 5'd5;
   localparam logic [OPC_W-1:0] OPC_RDMA         = 5'd7;
   localparam logic [OPC_W-1:0] OPC_ATOMIC       = 5'd9;
   localparam logic [OPC_W-1:0] OPC_RESP_READ    = 5'd10;
   localparam logic [OPC_W-1:0] OPC_RESP_WRITE   = 5'd11;
   localparam logic [OPC_W-1:0] OPC_LINK         = 5'd14;
   localparam logic [OPC_W-1:0] OPC_ERROR        = 5'd15;

   // Anything not listed carries data

endpackage

// File: verilog/lumi_tx_serializer.sv
`timescale 1ns/100ps

module lumi_tx_serializer
   import lumi_tx_pkg::*;
   (
      input  logic             clk,
      input  logic             nreset,
      input  logic [2:0]       csr_iowidth,   // Beat width in bytes: 1, 2 or 4
      input  logic             load,          // Take load_pkt this edge
      input  logic [PKT_W-1:0] load_pkt,
      input  logic [LEN_W-1:0] load_bytes,
      input  logic             phy_txrdy,
      output logic [IOW-1:0]   phy_txdata,
      output logic             phy_txvld,
      output logic             load_ready     // Free now or after this beat
   );

   logic [PKT_W-1:0]     shreg;        // Packet, LSB byte goes out first
   logic [PKT_BYTES-1:0] mask;         // One bit per byte still to send
   logic [PKT_BYTES-1:0] mask_next;
   logic [2:0]           step;         // Bytes per beat
   logic                 beat;         // Beat consumed by PHY
   logic                 last_beat;

   // Out-of-range widths fall back to full bus
   assign step = (csr_iowidth > IO_BYTES) ? 3'(IO_BYTES) : csr_iowidth;

   assign beat      = phy_txvld & phy_txrdy;
   assign mask_next = mask >> step;
   assign last_beat = ~|mask_next;     // Nothing left after current beat

   assign phy_txvld  = |mask;
   assign load_ready = ~phy_txvld | (last_beat & phy_txrdy);
   assign phy_txdata = shreg[IOW-1:0];

   //########################################
   // Byte-valid mask
   //########################################
   always_ff @(posedge clk or negedge nreset)
   begin
      if (!nreset)
         mask <= '0;
      else if (load)
         mask <= ~({PKT_BYTES{1'b1}} << load_bytes);  // Low load_bytes bits set
      else if (beat)
         mask <= mask_next;
   end

   //########################################
   // Data shift register
   //########################################
   always_ff @(posedge clk)
   begin
      if (load)
         shreg <= load_pkt;
      else if (beat)
         shreg <= shreg >> {step, 3'b000};   // Bytes to bits
      // Held under back-pressure
   end

endmodule

// File: verilog/lumi_tx_sizer.sv
`timescale 1ns/100ps

module lumi_tx_sizer
   import lumi_tx_pkg::*;
   (
      input  logic [CW-1:0]    cmd,        // Command word of pending packet
      output logic [LEN_W-1:0] pkt_bytes   // Bytes this packet puts on the wire
   );

   logic [OPC_W-1:0]    opc;
   logic [SIZE_W-1:0]   size;
   logic [LEN_W8-1:0]   len;
   logic [LEN_W8+7:0]   raw_bytes;   // 256 << 7 still fits
   logic [LEN_W-1:0]    data_bytes;

   // Field extraction
   assign opc  = cmd[OPC_LSB +: OPC_W];
   assign size = cmd[SIZE_LSB +: SIZE_W];
   assign len  = cmd[LEN_LSB +: LEN_W8];

   // Payload size from len/size clipped to the data field
   assign raw_bytes  = ((LEN_W8+8)'(len) + 1'b1) << size;
   assign data_bytes = (raw_bytes > DATA_BYTES) ? LEN_W'(DATA_BYTES)
                                                : raw_bytes[LEN_W-1:0];

   //########################################
   // Length by opcode class
   //########################################
   always_comb
   begin
      case (opc)
         OPC_INVALID,
         OPC_LINK:
            pkt_bytes = LEN_W'(CMD_BYTES);               // Cmd only
         OPC_READ,
         OPC_RDMA,
         OPC_ERROR,
         OPC_RESP_WRITE:
            pkt_bytes = LEN_W'(HDR_BYTES);               // Header without data
         // Writes, atomics, read responses and any unlisted op carry data
         default:
            pkt_bytes = LEN_W'(HDR_BYTES) + data_bytes;
      endcase
   end

endmodule

// File: verilog/lumi_txphy.sv
`timescale 1ns/100ps

module lumi_txphy
   import lumi_tx_pkg::*;
   (
      input  logic              clk,
      input  logic              nreset,
      // Static controls
      input  logic              csr_en,           // 1 = accept packets
      input  logic [2:0]        csr_iowidth,      // PHY beat width in bytes
      input  logic [CRDT_W-1:0] rmt_crdt_req,     // Remote byte limits
      input  logic [CRDT_W-1:0] rmt_crdt_resp,
      // Request channel
      input  logic              umi_req_in_valid,
      input  logic [CW-1:0]     umi_req_in_cmd,
      input  logic [AW-1:0]     umi_req_in_dstaddr,
      input  logic [AW-1:0]     umi_req_in_srcaddr,
      input  logic [DW-1:0]     umi_req_in_data,
      output logic              umi_req_in_ready,
      // Response channel
      input  logic              umi_resp_in_valid,
      input  logic [CW-1:0]     umi_resp_in_cmd,
      input  logic [AW-1:0]     umi_resp_in_dstaddr,
      input  logic [AW-1:0]     umi_resp_in_srcaddr,
      input  logic [DW-1:0]     umi_resp_in_data,
      output logic              umi_resp_in_ready,
      // PHY side
      output logic [IOW-1:0]    phy_txdata,
      output logic              phy_txvld,
      input  logic              phy_txrdy
   );

   logic [LEN_W-1:0] req_bytes;     // Pending packet lengths
   logic [LEN_W-1:0] resp_bytes;
   logic             req_crdt_ok;
   logic             resp_crdt_ok;
   logic             load_ready;
   logic             load;
   logic             load_resp;
   logic [PKT_W-1:0] load_pkt;
   logic [LEN_W-1:0] load_bytes;

   //########################################
   // Length decode per channel
   //########################################
   lumi_tx_sizer u_sizer_req (
      .cmd       (umi_req_in_cmd),
      .pkt_bytes (req_bytes)
   );

   lumi_tx_sizer u_sizer_resp (
      .cmd       (umi_resp_in_cmd),
      .pkt_bytes (resp_bytes)
   );

   // Credit check
   lumi_tx_credit u_credit (
      .clk (clk), .nreset (nreset),
      .load (load), .load_resp (load_resp), .load_bytes (load_bytes),
      .rmt_crdt_req (rmt_crdt_req), .rmt_crdt_resp (rmt_crdt_resp),
      .req_bytes (req_bytes), .resp_bytes (resp_bytes),
      .req_crdt_ok (req_crdt_ok), .resp_crdt_ok (resp_crdt_ok)
   );

   // Response-first arbiter and packet mux
   lumi_tx_arbiter u_arbiter (
      .csr_en (csr_en), .load_ready (load_ready),
      .req_crdt_ok (req_crdt_ok), .resp_crdt_ok (resp_crdt_ok),
      .req_bytes (req_bytes), .resp_bytes (resp_bytes),
      .umi_req_in_valid (umi_req_in_valid), .umi_req_in_cmd (umi_req_in_cmd),
      .umi_req_in_dstaddr (umi_req_in_dstaddr), .umi_req_in_srcaddr (umi_req_in_srcaddr),
      .umi_req_in_data (umi_req_in_data), .umi_req_in_ready (umi_req_in_ready),
      .umi_resp_in_valid (umi_resp_in_valid), .umi_resp_in_cmd (umi_resp_in_cmd),
      .umi_resp_in_dstaddr (umi_resp_in_dstaddr), .umi_resp_in_srcaddr (umi_resp_in_srcaddr),
      .umi_resp_in_data (umi_resp_in_data), .umi_resp_in_ready (umi_resp_in_ready),
      .load (load), .load_resp (load_resp), .load_pkt (load_pkt), .load_bytes (load_bytes)
   );

   // Byte serializer onto PHY
   lumi_tx_serializer u_serializer (
      .clk (clk), .nreset (nreset), .csr_iowidth (csr_iowidth),
      .load (load), .load_pkt (load_pkt), .load_bytes (load_bytes),
      .phy_txrdy (phy_txrdy), .phy_txdata (phy_txdata), .phy_txvld (phy_txvld),
      .load_ready (load_ready)
   );

endmodule
